/* Bender.yml */
package:
  name: core_glue

sources:
  - hw/core_ctrl_pkg.sv
  - hw/video_pkg.sv
  - hw/rtc_seconds.sv
  - hw/core_reset_gen.sv
  - hw/dataslot_target_ctrl.sv
  - hw/video_out_stage.sv
  - hw/core_glue_top.sv
  - target: test
    files:
      - testbench/core_glue_checker.sv
      - testbench/tb_core_glue.sv

/* hw/core_ctrl_pkg.sv */
// Control-side types and defaults for the system-clock glue.
// Defaults assume a 57.12 MHz system clock. Override them through the
// top-level parameters for simulation or other clock rates.

package core_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // wall clock

  // unix seconds as delivered by the host
  typedef logic [31:0] rtc_seconds_t;

  // one second of clk_sys_57_12
  parameter int unsigned DEF_TICKS_PER_SECOND = 57_120_000;

  ////////////////////////////////////////////////////////////////////////////
  // core reset

  // hold length after a menu or start-key reset
  parameter int unsigned DEF_RESET_HOLD = 65_535;

  ////////////////////////////////////////////////////////////////////////////
  // data slot requests

  // encoding matches the bridge target command type field
  typedef enum logic [1:0] {
    DS_READ     = 2'd0,
    DS_WRITE    = 2'd1,
    DS_GETFILE  = 2'd2,
    DS_OPENFILE = 2'd3
  } dataslot_req_e;

  typedef logic [31:0] bridge_addr_t;

  // long enough for the slower side to see the request level
  parameter int unsigned DEF_STRETCH_CYCLES = 7;

endpackage

/* hw/core_glue_top.sv */
// System-clock glue for the core with everything on clk_sys_57_12.
// Host-side inputs are assumed to be in this clock domain already.
// Only start_key may be asynchronous.

`timescale 1ns/1ps

module core_glue_top #(
  parameter int unsigned TICKS_PER_SECOND = core_ctrl_pkg::DEF_TICKS_PER_SECOND,
  parameter int unsigned RESET_HOLD       = core_ctrl_pkg::DEF_RESET_HOLD,
  parameter int unsigned STRETCH_CYCLES   = core_ctrl_pkg::DEF_STRETCH_CYCLES
) (
  input  logic                         clk_sys_57_12,
  input  logic                         rst,
  // reset sources
  input  logic                         host_run,
  input  logic                         menu_reset,
  input  logic                         start_key,
  input  logic                         enable_reset_plus,
  input  logic                         dataslot_requestwrite,
  input  logic                         dataslot_allcomplete,
  // wall clock
  input  logic                         rtc_valid,
  input  core_ctrl_pkg::rtc_seconds_t  rtc_epoch,
  // data slot requests
  input  logic                         req_read,
  input  logic                         req_write,
  input  logic                         req_getfile,
  input  logic                         req_openfile,
  input  core_ctrl_pkg::bridge_addr_t  ram_data_address,
  input  logic                         target_done,
  // video from the soft core
  input  video_pkg::rgb565_t           pixel,
  input  logic                         de,
  input  logic                         hsync,
  input  logic                         vsync,
  input  video_pkg::scaler_slot_t      scaler_slot,
  // outputs
  output logic                         core_reset,
  output core_ctrl_pkg::rtc_seconds_t  rtc_now,
  output logic                         target_request,
  output core_ctrl_pkg::dataslot_req_e target_type,
  output core_ctrl_pkg::bridge_addr_t  target_ram_address,
  output logic                         complete_trigger,
  output video_pkg::rgb888_t           video_rgb,
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs
);

  rtc_seconds #(
    .TICKS_PER_SECOND(TICKS_PER_SECOND)
  ) i_rtc_seconds (
    .clk_sys_57_12(clk_sys_57_12),
    .rst          (rst),
    .rtc_valid    (rtc_valid),
    .rtc_epoch    (rtc_epoch),
    .rtc_now      (rtc_now)
  );

  core_reset_gen #(
    .RESET_HOLD(RESET_HOLD)
  ) i_core_reset_gen (
    .clk_sys_57_12        (clk_sys_57_12),
    .rst                  (rst),
    .host_run             (host_run),
    .menu_reset           (menu_reset),
    .start_key            (start_key),
    .enable_reset_plus    (enable_reset_plus),
    .dataslot_requestwrite(dataslot_requestwrite),
    .dataslot_allcomplete (dataslot_allcomplete),
    .core_reset           (core_reset)
  );

  dataslot_target_ctrl #(
    .STRETCH_CYCLES(STRETCH_CYCLES)
  ) i_dataslot_target_ctrl (
    .clk_sys_57_12     (clk_sys_57_12),
    .rst               (rst),
    .req_read          (req_read),
    .req_write         (req_write),
    .req_getfile       (req_getfile),
    .req_openfile      (req_openfile),
    .ram_data_address  (ram_data_address),
    .target_done       (target_done),
    .target_request    (target_request),
    .target_type       (target_type),
    .target_ram_address(target_ram_address),
    .complete_trigger  (complete_trigger)
  );

  video_out_stage i_video_out_stage (
    .clk_sys_57_12(clk_sys_57_12),
    .rst          (rst),
    .pixel        (pixel),
    .de           (de),
    .hsync        (hsync),
    .vsync        (vsync),
    .scaler_slot  (scaler_slot),
    .video_rgb    (video_rgb),
    .video_de     (video_de),
    .video_hs     (video_hs),
    .video_vs     (video_vs)
  );

endmodule

/* hw/core_reset_gen.sv */
// Core reset from host run flag, download window and a hold timer.
// start_key is asynchronous and gets a two-flop synchronizer here.
// menu_reset must already be a single-cycle pulse on clk_sys_57_12.
// core_reset comes out of reset high.

`timescale 1ns/1ps

module core_reset_gen #(
  parameter int unsigned RESET_HOLD = core_ctrl_pkg::DEF_RESET_HOLD
) (
  input  logic clk_sys_57_12,
  input  logic rst,
  input  logic host_run,
  input  logic menu_reset,
  input  logic start_key,
  input  logic enable_reset_plus,
  input  logic dataslot_requestwrite,
  input  logic dataslot_allcomplete,
  output logic core_reset
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  logic              start_key_meta;
  logic              start_key_sync;
  logic              start_key_prev;
  logic              start_edge;
  logic              hold_trigger;
  logic [HOLD_W-1:0] hold_timer;
  logic              download_flag;
  logic              download_next;

  assign start_edge    = start_key_sync & ~start_key_prev;
  assign hold_trigger  = menu_reset | (start_edge & enable_reset_plus);
  assign download_next = dataslot_requestwrite | (download_flag & ~dataslot_allcomplete);

  // start key synchronizer and edge detect
  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      start_key_meta <= 1'b0;
      start_key_sync <= 1'b0;
      start_key_prev <= 1'b0;
    end else begin
      start_key_meta <= start_key;
      start_key_sync <= start_key_meta;
      start_key_prev <= start_key_sync;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // hold timer, download window and reset output

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      hold_timer    <= '0;
      download_flag <= 1'b0;
      core_reset    <= 1'b1;
    end else begin
      if (hold_trigger) begin
        hold_timer <= HOLD_W'(RESET_HOLD);
      end else if (hold_timer != '0) begin
        hold_timer <= hold_timer - HOLD_W'(1);
      end
      download_flag <= download_next;
      // trigger term makes the reset start one cycle after the pulse
      core_reset    <= ~host_run | download_next | hold_trigger | (hold_timer != '0);
    end
  end

  // the core stays in reset for the whole download window
  a_download_holds: assert property (@(posedge clk_sys_57_12) disable iff (rst)
    download_flag |-> core_reset);

endmodule

/* hw/dataslot_target_ctrl.sv */
// Turns soft-core data slot request edges into a stretched request level.
// Read wins over write, getfile and openfile when edges coincide.
// A new edge during a stretch restarts it with the new type.
// target_ram_address follows ram_data_address while any request is high.

`timescale 1ns/1ps

module dataslot_target_ctrl #(
  parameter int unsigned STRETCH_CYCLES = core_ctrl_pkg::DEF_STRETCH_CYCLES
) (
  input  logic                         clk_sys_57_12,
  input  logic                         rst,
  input  logic                         req_read,
  input  logic                         req_write,
  input  logic                         req_getfile,
  input  logic                         req_openfile,
  input  core_ctrl_pkg::bridge_addr_t  ram_data_address,
  input  logic                         target_done,
  output logic                         target_request,
  output core_ctrl_pkg::dataslot_req_e target_type,
  output core_ctrl_pkg::bridge_addr_t  target_ram_address,
  output logic                         complete_trigger
);
  import core_ctrl_pkg::*;

  localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

  logic [3:0]       req_vec;
  logic [3:0]       req_prev;
  logic [3:0]       req_rise;
  logic             req_edge;
  logic [CNT_W-1:0] stretch_cnt;
  logic             target_done_prev;
  dataslot_req_e    next_type;

  // bit order follows the type encoding
  assign req_vec  = {req_openfile, req_getfile, req_write, req_read};
  assign req_rise = req_vec & ~req_prev;
  assign req_edge = |req_rise;

  always_comb begin
    if (req_rise[0]) next_type = DS_READ;
    else if (req_rise[1]) next_type = DS_WRITE;
    else if (req_rise[2]) next_type = DS_GETFILE;
    else if (req_rise[3]) next_type = DS_OPENFILE;
    else next_type = target_type;
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      req_prev         <= '0;
      stretch_cnt      <= '0;
      target_type      <= DS_READ;
      target_done_prev <= 1'b0;
      complete_trigger <= 1'b0;
    end else begin
      req_prev         <= req_vec;
      target_done_prev <= target_done;
      complete_trigger <= target_done & ~target_done_prev;
      if (req_edge) begin
        stretch_cnt <= CNT_W'(STRETCH_CYCLES);
        target_type <= next_type;
      end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - CNT_W'(1);
      end
    end
  end

  assign target_request = (stretch_cnt != '0);

  // address is taken while the soft core holds its request
  always_ff @(posedge clk_sys_57_12) begin
    if (|req_vec) begin
      target_ram_address <= ram_data_address;
    end
  end

  a_stretch_len: assert property (@(posedge clk_sys_57_12) disable iff (rst)
    (!req_edge) [*STRETCH_CYCLES] |=> !target_request);

endmodule

/* hw/rtc_seconds.sv */
// Seconds counter loaded from the host epoch on a rising edge of rtc_valid.
// Accuracy depends on TICKS_PER_SECOND matching the real clock rate.
// Counts from zero until the first epoch load.

`timescale 1ns/1ps

module rtc_seconds #(
  parameter int unsigned TICKS_PER_SECOND = core_ctrl_pkg::DEF_TICKS_PER_SECOND
) (
  input  logic                        clk_sys_57_12,
  input  logic                        rst,
  input  logic                        rtc_valid,
  input  core_ctrl_pkg::rtc_seconds_t rtc_epoch,
  output core_ctrl_pkg::rtc_seconds_t rtc_now
);
  import core_ctrl_pkg::*;

  localparam int TICK_W = $clog2(TICKS_PER_SECOND + 1);
  localparam logic [TICK_W-1:0] TICK_RELOAD = TICK_W'(TICKS_PER_SECOND - 1);

  logic              rtc_valid_prev;
  logic              rtc_load;
  logic [TICK_W-1:0] tick_cnt;

  assign rtc_load = rtc_valid & ~rtc_valid_prev;

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      rtc_valid_prev <= 1'b0;
      tick_cnt       <= TICK_RELOAD;
      rtc_now        <= '0;
    end else begin
      rtc_valid_prev <= rtc_valid;
      if (rtc_load) begin
        // epoch load restarts the second
        rtc_now  <= rtc_epoch;
        tick_cnt <= TICK_RELOAD;
      end else if (tick_cnt == '0) begin
        rtc_now  <= rtc_now + rtc_seconds_t'(1);
        tick_cnt <= TICK_RELOAD;
      end else begin
        tick_cnt <= tick_cnt - TICK_W'(1);
      end
    end
  end

  // outside an epoch load the wall clock only ever steps by one second
  a_rtc_step: assert property (@(posedge clk_sys_57_12) disable iff (rst)
    !$past(rtc_load) |-> (rtc_seconds_t'(rtc_now - $past(rtc_now)) <= rtc_seconds_t'(1)));

endmodule

/* hw/video_out_stage.sv */
// RGB565 to RGB888 output stage for the scaler with all outputs one cycle late.
// DE is widened to three cycles to leave a blank column at the line end.
// The pixel slot after each line carries the scaler slot for the next line.

`timescale 1ns/1ps

module video_out_stage (
  input  logic                    clk_sys_57_12,
  input  logic                    rst,
  input  video_pkg::rgb565_t      pixel,
  input  logic                    de,
  input  logic                    hsync,
  input  logic                    vsync,
  input  video_pkg::scaler_slot_t scaler_slot,
  output video_pkg::rgb888_t      video_rgb,
  output logic                    video_de,
  output logic                    video_hs,
  output logic                    video_vs
);
  import video_pkg::*;

  logic    de_d1;
  logic    de_d2;
  rgb888_t pixel_rgb888;
  rgb888_t eol_word;

  // top bits fill the low end so full scale stays full scale
  function automatic rgb888_t expand_565(input rgb565_t px);
    rgb888_t wide;
    wide.red   = {px.red, px.red[4:2]};
    wide.green = {px.green, px.green[5:4]};
    wide.blue  = {px.blue, px.blue[4:2]};
    return wide;
  endfunction

  assign pixel_rgb888 = expand_565(pixel);
  assign eol_word     = rgb888_t'(24'(scaler_slot) << EOL_SLOT_LSB);

  ////////////////////////////////////////////////////////////////////////////
  // timing signals

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      de_d1    <= 1'b0;
      de_d2    <= 1'b0;
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      de_d1    <= de;
      de_d2    <= de_d1;
      video_de <= de | de_d1 | de_d2;
      video_hs <= hsync;
      video_vs <= vsync;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pixel data

  // video_de still high after de dropped marks the end-of-line slots
  always_ff @(posedge clk_sys_57_12) begin
    if (de) begin
      video_rgb <= pixel_rgb888;
    end else if (video_de) begin
      video_rgb <= eol_word;
    end else begin
      video_rgb <= '0;
    end
  end

  // each active cycle keeps video_de up for the whole three-cycle window
  a_de_widen: assert property (@(posedge clk_sys_57_12) disable iff (rst)
    de |=> video_de [*3]);

endmodule

/* hw/video_pkg.sv */
// Pixel formats and end-of-line word layout for the video output stage.
// The end-of-line word is only meaningful in the pixel slot after DE.

package video_pkg;

  // soft core pixel with 5/6/5 bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // scaler pixel with 8 bits per color
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // selects one of the scaler modes set up by the host
  typedef logic [2:0] scaler_slot_t;

  // slot field position inside the end-of-line word
  parameter int EOL_SLOT_LSB = 13;

endpackage

/* tb.f */
hw/core_ctrl_pkg.sv
hw/video_pkg.sv
hw/rtc_seconds.sv
hw/core_reset_gen.sv
hw/dataslot_target_ctrl.sv
hw/video_out_stage.sv
hw/core_glue_top.sv
testbench/core_glue_checker.sv
testbench/tb_core_glue.sv

/* testbench/core_glue_checker.sv */
// Watches the glue ports and compares them against expected behavior.
// Sampling is on the falling clock edge, where inputs and outputs are stable.
// The video model runs every cycle and its mismatches count against
// whichever test is open at the time.

`timescale 1ns/1ps

module core_glue_checker #(
  parameter int unsigned TICKS_PER_SECOND = core_ctrl_pkg::DEF_TICKS_PER_SECOND,
  parameter int unsigned RESET_HOLD       = core_ctrl_pkg::DEF_RESET_HOLD,
  parameter int unsigned STRETCH_CYCLES   = core_ctrl_pkg::DEF_STRETCH_CYCLES
) (
  input logic                         clk_sys_57_12,
  input logic                         rst,
  input logic                         core_reset,
  input core_ctrl_pkg::rtc_seconds_t  rtc_now,
  input logic                         target_request,
  input core_ctrl_pkg::dataslot_req_e target_type,
  input core_ctrl_pkg::bridge_addr_t  target_ram_address,
  input logic                         complete_trigger,
  input video_pkg::rgb565_t           pixel,
  input logic                         de,
  input logic                         hsync,
  input logic                         vsync,
  input video_pkg::scaler_slot_t      scaler_slot,
  input video_pkg::rgb888_t           video_rgb,
  input logic                         video_de,
  input logic                         video_hs,
  input logic                         video_vs
);
  import core_ctrl_pkg::*;
  import video_pkg::*;

  int           check_count = 0;
  int           error_count = 0;
  int           test_count = 0;
  int           failed_tests = 0;
  int           errors_at_start = 0;
  logic [127:0] test_name;

  task automatic compare(input string sig, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL t=%0t %s got=%h exp=%h", $time, sig, got, exp);
    end
  endtask

  task automatic complain(input string what);
    error_count++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  task automatic begin_test(input logic [127:0] name);
    test_name       = name;
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == errors_at_start) begin
      $display("test %0d %0s: ok", test_count, test_name);
    end else begin
      failed_tests++;
      $display("test %0d %0s: %0d errors", test_count, test_name,
               error_count - errors_at_start);
    end
  endtask

  task automatic report_counts();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // wall clock

  task automatic check_rtc(input rtc_seconds_t epoch, input int wait_cycles);
    int           n;
    int unsigned  lo;
    int unsigned  hi;
    rtc_seconds_t delta;
    n = 0;
    while (rtc_now !== epoch && n < 8) begin
      @(negedge clk_sys_57_12);
      n++;
    end
    if (rtc_now !== epoch) begin
      complain("rtc_now never took the epoch after rtc_valid rose");
      return;
    end
    // edge sampled one cycle after the drive, epoch visible the cycle after
    compare("rtc_now load delay", n, 2);
    repeat (wait_cycles) @(negedge clk_sys_57_12);
    // either rounding of elapsed seconds is fine
    lo    = wait_cycles / TICKS_PER_SECOND;
    hi    = (wait_cycles + TICKS_PER_SECOND - 1) / TICKS_PER_SECOND;
    delta = rtc_now - epoch;
    check_count++;
    if (delta < lo || delta > hi) begin
      error_count++;
      $display("FAIL t=%0t rtc_now got=%h exp=%h..%h", $time, rtc_now, epoch + lo, epoch + hi);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // core reset

  task automatic wait_reset_low(input int limit);
    int n;
    n = 0;
    while (core_reset && n < limit) begin
      @(negedge clk_sys_57_12);
      n++;
    end
    if (core_reset) complain("core_reset did not fall in time");
    else check_count++;
  endtask

  task automatic measure_reset(input logic expect_reset);
    int n;
    int width;
    n = 0;
    // start key adds its synchronizer latency here
    while (!core_reset && n < 8) begin
      @(negedge clk_sys_57_12);
      n++;
    end
    compare("core_reset", core_reset, expect_reset);
    if (core_reset && expect_reset) begin
      width = 0;
      while (core_reset && width < RESET_HOLD + 20) begin
        @(negedge clk_sys_57_12);
        width++;
      end
      check_count++;
      if (width < RESET_HOLD || width > RESET_HOLD + 4) begin
        error_count++;
        $display("FAIL t=%0t core_reset width got=%0d exp=%0d..%0d",
                 $time, width, RESET_HOLD, RESET_HOLD + 4);
      end
    end
  endtask

  task automatic check_reset_held(input int cycles, input logic exp);
    repeat (cycles) begin
      @(negedge clk_sys_57_12);
      compare("core_reset", core_reset, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // data slot requests and completion

  task automatic check_request(input dataslot_req_e exp_type, input bridge_addr_t exp_addr);
    int n;
    int width;
    n = 0;
    while (!target_request && n < 4) begin
      @(negedge clk_sys_57_12);
      n++;
    end
    if (!target_request) begin
      complain("target_request did not rise after the request edge");
      return;
    end
    compare("target_request delay", n, 1);
    compare("target_type", target_type, exp_type);
    compare("target_ram_address", target_ram_address, exp_addr);
    width = 0;
    while (target_request && width < STRETCH_CYCLES + 8) begin
      @(negedge clk_sys_57_12);
      width++;
    end
    compare("target_request width", width, STRETCH_CYCLES);
  endtask

  task automatic check_complete(input int hold_cycles);
    int n;
    int pulses;
    n = 0;
    while (!complete_trigger && n < 4) begin
      @(negedge clk_sys_57_12);
      n++;
    end
    compare("complete_trigger delay", n, 1);
    pulses = 0;
    repeat (hold_cycles + 2) begin
      if (complete_trigger) pulses++;
      @(negedge clk_sys_57_12);
    end
    compare("complete_trigger pulses", pulses, 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // video reference model

  // top bits of each color refill the low end
  function automatic rgb888_t widen(input rgb565_t p);
    rgb888_t w;
    w.red   = (8'(p.red) << 3) | (8'(p.red) >> 2);
    w.green = (8'(p.green) << 2) | (8'(p.green) >> 4);
    w.blue  = (8'(p.blue) << 3) | (8'(p.blue) >> 2);
    return w;
  endfunction

  logic        exp_valid;
  logic        exp_de;
  logic        exp_hs;
  logic        exp_vs;
  logic        de_h1;
  logic        de_h2;
  logic [23:0] eol_exp;
  rgb888_t     exp_rgb;

  always @(negedge clk_sys_57_12) begin
    if (rst) begin
      exp_valid = 1'b0;
      exp_de    = 1'b0;
      de_h1     = 1'b0;
      de_h2     = 1'b0;
    end else begin
      if (exp_valid) begin
        compare("video_rgb", video_rgb, exp_rgb);
        compare("video_de", video_de, exp_de);
        compare("video_hs", video_hs, exp_hs);
        compare("video_vs", video_vs, exp_vs);
      end
      if (de) begin
        exp_rgb = widen(pixel);
      end else if (exp_de) begin
        // slot field alone in an otherwise zero word
        eol_exp = '0;
        eol_exp[EOL_SLOT_LSB +: $bits(scaler_slot_t)] = scaler_slot;
        exp_rgb = eol_exp;
      end else begin
        exp_rgb = '0;
      end
      exp_de    = de | de_h1 | de_h2;
      de_h2     = de_h1;
      de_h1     = de;
      exp_hs    = hsync;
      exp_vs    = vsync;
      exp_valid = 1'b1;
    end
  end

endmodule

/* testbench/core_glue_stimulus.txt */
# columns: name op a b c (op decimal, a b c hex)
# op 1 rtc a=epoch b=wait c=exp epoch, 2-5 reset c=exp level, 6 req a=type b=addr c=exp type
rtc_load 1 65a1b2c3 23 65a1b2c3
rtc_reload 1 00001000 7 00001000
menu_reset 2 0 0 1
key_no_plus 3 0 0 0
key_plus 3 1 0 1
download 4 14 0 1
host_stop 5 9 0 1
req_read 6 0 10002000 0
req_write 6 1 10002040 1
req_getfile 6 2 2000abc0 2
req_openfile 6 3 00fffffc 3
done_pulse 7 3 0 1
video_slot5 8 3 10 5
video_slot2 8 2 7 2

/* testbench/tb_core_glue.sv */
// Testbench for the system-clock glue that reads its steps from the stimulus file.
// Must be run from the project root so the file path resolves.

`timescale 1ns/1ps

module tb_core_glue;
  import core_ctrl_pkg::*;
  import video_pkg::*;

  localparam int unsigned TICKS    = 10;
  localparam int unsigned HOLD     = 12;
  localparam int unsigned STRETCH  = 7;
  localparam int          WATCHDOG = 20000;

  logic clk_sys_57_12 = 1'b0;
  logic rst, host_run, menu_reset, start_key, enable_reset_plus;
  logic dataslot_requestwrite, dataslot_allcomplete, rtc_valid;
  logic req_read, req_write, req_getfile, req_openfile, target_done;
  logic de, hsync, vsync;
  rtc_seconds_t  rtc_epoch;
  bridge_addr_t  ram_data_address;
  rgb565_t       pixel;
  scaler_slot_t  scaler_slot;
  logic          core_reset, target_request, complete_trigger;
  logic          video_de, video_hs, video_vs;
  rtc_seconds_t  rtc_now;
  dataslot_req_e target_type;
  bridge_addr_t  target_ram_address;
  rgb888_t       video_rgb;
  logic [31:0]   lcg_state = 32'd84095;

  always #10 clk_sys_57_12 = ~clk_sys_57_12;

  core_glue_top #(
    .TICKS_PER_SECOND(TICKS), .RESET_HOLD(HOLD), .STRETCH_CYCLES(STRETCH)
  ) i_core_glue_top (.*);

  core_glue_checker #(
    .TICKS_PER_SECOND(TICKS), .RESET_HOLD(HOLD), .STRETCH_CYCLES(STRETCH)
  ) i_checker (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic play_video(input int lines, input int width, input scaler_slot_t slot);
    for (int ln = 0; ln < lines; ln++) begin
      for (int px = 0; px < width; px++) begin
        @(posedge clk_sys_57_12);
        lcg_state = lcg_next(lcg_state);
        de          <= 1'b1;
        pixel       <= rgb565_t'(lcg_state[31:16]);
        scaler_slot <= slot;
        hsync       <= 1'b0;
        vsync       <= 1'b0;
      end
      // blanking with vsync only after the first line
      for (int gap = 0; gap < 5; gap++) begin
        @(posedge clk_sys_57_12);
        de    <= 1'b0;
        pixel <= '0;
        hsync <= (gap == 1);
        vsync <= (ln == 0 && gap >= 1);
      end
    end
    @(posedge clk_sys_57_12);
    hsync <= 1'b0;
    vsync <= 1'b0;
    repeat (4) @(posedge clk_sys_57_12);
  endtask

  task automatic run_step(input logic [127:0] name, input int op,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
    i_checker.begin_test(name);
    case (op)
      1: begin
        @(posedge clk_sys_57_12);
        rtc_epoch <= a;
        rtc_valid <= 1'b1;
        i_checker.check_rtc(c, b);
        @(posedge clk_sys_57_12);
        rtc_valid <= 1'b0;
      end
      2: begin
        i_checker.wait_reset_low(HOLD + 20);
        @(posedge clk_sys_57_12);
        menu_reset <= 1'b1;
        @(posedge clk_sys_57_12);
        menu_reset <= 1'b0;
        i_checker.measure_reset(c[0]);
      end
      3: begin
        i_checker.wait_reset_low(HOLD + 20);
        @(posedge clk_sys_57_12);
        enable_reset_plus <= a[0];
        start_key         <= 1'b1;
        i_checker.measure_reset(c[0]);
        @(posedge clk_sys_57_12);
        start_key         <= 1'b0;
        enable_reset_plus <= 1'b0;
        repeat (4) @(posedge clk_sys_57_12);
      end
      4: begin
        i_checker.wait_reset_low(HOLD + 20);
        @(posedge clk_sys_57_12);
        dataslot_requestwrite <= 1'b1;
        @(posedge clk_sys_57_12);
        dataslot_requestwrite <= 1'b0;
        i_checker.check_reset_held(a, c[0]);
        @(posedge clk_sys_57_12);
        dataslot_allcomplete <= 1'b1;
        @(posedge clk_sys_57_12);
        dataslot_allcomplete <= 1'b0;
        i_checker.wait_reset_low(3);
      end
      5: begin
        i_checker.wait_reset_low(HOLD + 20);
        @(posedge clk_sys_57_12);
        host_run <= 1'b0;
        @(posedge clk_sys_57_12);
        i_checker.check_reset_held(a, c[0]);
        @(posedge clk_sys_57_12);
        host_run <= 1'b1;
        i_checker.wait_reset_low(4);
      end
      6: begin
        @(posedge clk_sys_57_12);
        req_read         <= (a == 0);
        req_write        <= (a == 1);
        req_getfile      <= (a == 2);
        req_openfile     <= (a == 3);
        ram_data_address <= b;
        @(posedge clk_sys_57_12);
        i_checker.check_request(dataslot_req_e'(c[1:0]), b);
        @(posedge clk_sys_57_12);
        {req_read, req_write, req_getfile, req_openfile} <= 4'b0000;
        @(posedge clk_sys_57_12);
      end
      7: begin
        @(posedge clk_sys_57_12);
        target_done <= 1'b1;
        @(posedge clk_sys_57_12);
        i_checker.check_complete(a);
        @(posedge clk_sys_57_12);
        target_done <= 1'b0;
        @(posedge clk_sys_57_12);
      end
      8: play_video(a, b, c[2:0]);
      default: i_checker.complain("unknown operation code in the stimulus file");
    endcase
    i_checker.end_test();
  endtask

  initial begin
    int                fd;
    int                op;
    int                fields;
    logic              open_ok;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       c;
    logic [127:0]      name;
    logic [8*128-1:0]  line_buf;
    rst <= 1'b1;
    host_run <= 1'b1;
    {menu_reset, start_key, enable_reset_plus} <= 3'b000;
    {dataslot_requestwrite, dataslot_allcomplete, rtc_valid} <= 3'b000;
    {req_read, req_write, req_getfile, req_openfile, target_done} <= 5'b00000;
    {de, hsync, vsync} <= 3'b000;
    rtc_epoch        <= '0;
    ram_data_address <= '0;
    pixel            <= '0;
    scaler_slot      <= '0;
    repeat (5) @(posedge clk_sys_57_12);
    rst <= 1'b0;
    repeat (2) @(posedge clk_sys_57_12);
    fd      = $fopen("testbench/core_glue_stimulus.txt", "r");
    open_ok = (fd != 0);
    if (!open_ok) begin
      $display("could not open testbench/core_glue_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        if ($fgets(line_buf, fd) != 0) begin
          fields = $sscanf(line_buf, "%s %d %h %h %h", name, op, a, b, c);
          // comment and blank lines do not yield five fields
          if (fields == 5) run_step(name, op, a, b, c);
        end
      end
      $fclose(fd);
    end
    i_checker.report_counts();
    if (open_ok && i_checker.error_count == 0 && i_checker.test_count > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk_sys_57_12);
    $display("watchdog expired before the test sequence finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule
